// ==== src/cache_pkg.sv ====
// Banked cache shared definitions
// Address split, opcodes, FSM states and the message formats

`default_nettype none

package cache_pkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_BANKS      = 4;
  localparam int BANK_W         = 2;   // Address bits 5:4
  localparam int LINES_PER_BANK = 8;
  localparam int IDX_W          = 3;   // Address bits 8:6
  localparam int TAG_W          = 23;  // Address bits 31:9
  localparam int OPQ_W          = 8;
  localparam int CLIENT_CREDITS = 2;   // Router buffer depth

  // ------------------------------
  // Opcodes and states
  // ------------------------------
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } cache_op_e;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE,
    WRITE_HIT,
    RESPOND
  } bank_state_e;

  // ------------------------------
  // Messages
  // ------------------------------
  typedef struct packed {
    cache_op_e         op;
    logic [OPQ_W-1:0]  opaque;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cache_req_t;

  typedef struct packed {
    cache_op_e         op;
    logic [OPQ_W-1:0]  opaque;
    logic [DATA_W-1:0] data;     // Zero for writes
  } cache_resp_t;

  typedef struct packed {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;     // Line aligned
    logic [LINE_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_op_e           op;
    logic [LINE_W-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

// ==== src/bank_router.sv ====
// Bank router
// Buffers client requests and forwards the oldest one to its bank on credit

`timescale 1ns/1ps
`default_nettype none

module bank_router import cache_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid,
  input  cache_req_t           req,
  input  logic [NUM_BANKS-1:0] bank_req_credit,
  output logic                 req_credit,
  output logic [NUM_BANKS-1:0] bank_req_valid,
  output cache_req_t           bank_req
);

  cache_req_t                            fifo_q [CLIENT_CREDITS];
  logic [$clog2(CLIENT_CREDITS)-1:0]     wr_ptr_q;
  logic [$clog2(CLIENT_CREDITS)-1:0]     rd_ptr_q;
  logic [$clog2(CLIENT_CREDITS+1)-1:0]   count_q;
  logic [NUM_BANKS-1:0]                  bank_cred_q;  // One credit per bank
  logic [BANK_W-1:0]                     head_bank;
  logic                                  fwd;

  assign bank_req  = fifo_q[rd_ptr_q];
  assign head_bank = bank_req.addr[4 +: BANK_W];
  // No bypass, a blocked head holds back the entry behind it
  assign fwd        = (count_q != '0) && bank_cred_q[head_bank];
  assign req_credit = fwd;

  always_comb begin
    bank_req_valid            = '0;
    bank_req_valid[head_bank] = fwd;
  end

  always_ff @(posedge clk) begin
    if (req_valid) fifo_q[wr_ptr_q] <= req;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      bank_cred_q <= '1;
    end else begin
      if (req_valid) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (fwd) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({req_valid, fwd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      bank_cred_q <= (bank_cred_q & ~bank_req_valid) | bank_req_credit;
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_bank_dpath.sv ====
// Cache bank datapath
// Request and refill registers, tag and data arrays, evict path and packing

`timescale 1ns/1ps
`default_nettype none

module cache_bank_dpath import cache_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bank_req_valid,
  input  cache_req_t                bank_req,
  input  logic                      memresp_valid,
  input  mem_resp_t                 memresp,
  input  logic                      write_data_sel,
  input  logic                      tag_wen,
  input  logic                      data_wen,
  input  logic [WORDS_PER_LINE-1:0] word_en,
  input  logic                      evict_en,
  input  logic                      memreq_addr_sel,
  input  cache_op_e                 resp_op,
  input  mem_op_e                   mem_op,
  output logic                      tag_match,
  output mem_req_t                  memreq,
  output cache_resp_t               cacheresp
);

  cache_req_t        req_q;
  logic [LINE_W-1:0] refill_q;
  logic [LINE_W-1:0] wd;
  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  req_tag, read_tag;
  logic [LINE_W-1:0] read_line, rd_line_q;
  logic [ADDR_W-1:0] victim_addr, refill_addr, evict_addr_q;
  logic [DATA_W-1:0] read_word;

  logic [TAG_W-1:0]  tag_array  [LINES_PER_BANK];
  logic [LINE_W-1:0] data_array [LINES_PER_BANK];

  // ------------------------------
  // Request side
  // ------------------------------
  always_ff @(posedge clk) begin
    if (bank_req_valid) req_q <= bank_req;  // Opaque, op, addr and store word
    if (memresp_valid) refill_q <= memresp.data;
  end

  // Store word goes to every lane, word_en picks the one written
  assign wd = write_data_sel ? refill_q : {WORDS_PER_LINE{req_q.data}};

  assign idx     = req_q.addr[6 +: IDX_W];
  assign req_tag = req_q.addr[ADDR_W-1 -: TAG_W];

  always_ff @(posedge clk) begin
    if (tag_wen) tag_array[idx] <= req_tag;
    if (data_wen) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        if (word_en[w]) data_array[idx][w*DATA_W +: DATA_W] <= wd[w*DATA_W +: DATA_W];
      end
    end
  end

  assign read_tag  = tag_array[idx];
  assign read_line = data_array[idx];
  assign tag_match = (read_tag == req_tag);

  // ------------------------------
  // Memory side
  // ------------------------------
  assign victim_addr = {read_tag, idx, req_q.addr[5:4], 4'b0000};
  assign refill_addr = {req_q.addr[ADDR_W-1:4], 4'b0000};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) evict_addr_q <= '0;
    else if (evict_en) evict_addr_q <= victim_addr;
  end

  // Line as read at the index one cycle earlier
  always_ff @(posedge clk) begin
    rd_line_q <= read_line;
  end

  assign read_word = rd_line_q[req_q.addr[3:2]*DATA_W +: DATA_W];

  assign cacheresp.op     = resp_op;
  assign cacheresp.opaque = req_q.opaque;
  assign cacheresp.data   = (resp_op == OP_READ) ? read_word : '0;

  assign memreq.op   = mem_op;
  assign memreq.addr = memreq_addr_sel ? refill_addr : evict_addr_q;
  assign memreq.data = rd_line_q;   // Victim line on a write back

endmodule

`default_nettype wire

// ==== src/cache_bank.sv ====
// Cache bank control
// Blocking direct-mapped write-back FSM around cache_bank_dpath

`timescale 1ns/1ps
`default_nettype none

module cache_bank import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        bank_req_valid,
  input  cache_req_t  bank_req,
  input  logic        mem_credit,
  input  logic        memresp_valid,
  input  mem_resp_t   memresp,
  input  logic        resp_credit,
  output logic        bank_req_credit,
  output logic        memreq_valid,
  output mem_req_t    memreq,
  output logic        cacheresp_valid,
  output cache_resp_t cacheresp
);

  bank_state_e               state_q, state_d;
  logic [LINES_PER_BANK-1:0] valid_q, dirty_q;
  logic                      mem_cred_q, resp_cred_q;
  cache_op_e                 req_op;
  logic [IDX_W-1:0]          req_idx;
  logic [1:0]                req_word;
  logic                      tag_match, hit;

  logic                      write_data_sel, tag_wen, data_wen, evict_en, memreq_addr_sel;
  logic [WORDS_PER_LINE-1:0] word_en;
  mem_op_e                   mem_op;

  assign hit = valid_q[req_idx] && tag_match;

  // Control copy of the request fields
  always_ff @(posedge clk) begin
    if (bank_req_valid) begin
      req_op   <= bank_req.op;
      req_idx  <= bank_req.addr[6 +: IDX_W];
      req_word <= bank_req.addr[3:2];
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:          if (bank_req_valid) state_d = TAG_CHECK;
      TAG_CHECK: begin
        if (hit) state_d = RESPOND;   // Write hits store here
        else if (dirty_q[req_idx]) state_d = EVICT_REQ;
        else state_d = REFILL_REQ;
      end
      EVICT_REQ:     if (mem_cred_q) state_d = EVICT_WAIT;
      EVICT_WAIT:    if (memresp_valid) state_d = REFILL_REQ;
      REFILL_REQ:    if (mem_cred_q) state_d = REFILL_WAIT;
      REFILL_WAIT:   if (memresp_valid) state_d = REFILL_UPDATE;
      // Reads recheck so the read data register sees the new line
      REFILL_UPDATE: state_d = (req_op == OP_WRITE) ? WRITE_HIT : TAG_CHECK;
      WRITE_HIT:     state_d = RESPOND;
      RESPOND:       if (resp_cred_q) state_d = IDLE;
      default:       state_d = IDLE;
    endcase
  end

  // Datapath controls
  always_comb begin
    word_en           = '0;
    word_en[req_word] = 1'b1;
    if (state_q == REFILL_UPDATE) word_en = '1;   // Whole line on refill
  end

  assign write_data_sel  = (state_q == REFILL_UPDATE);
  assign tag_wen         = (state_q == REFILL_UPDATE);
  assign data_wen        = (state_q == TAG_CHECK && hit && req_op == OP_WRITE) ||
                           (state_q == WRITE_HIT) || (state_q == REFILL_UPDATE);
  assign evict_en        = (state_q == TAG_CHECK) && !hit;
  assign memreq_addr_sel = (state_q == REFILL_REQ);
  assign mem_op          = (state_q == EVICT_REQ) ? MEM_WRITE : MEM_READ;

  assign memreq_valid    = (state_q == EVICT_REQ || state_q == REFILL_REQ) && mem_cred_q;
  assign cacheresp_valid = (state_q == RESPOND) && resp_cred_q;
  assign bank_req_credit = cacheresp_valid;   // Back to idle next cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      valid_q     <= '0;
      dirty_q     <= '0;
      mem_cred_q  <= 1'b1;
      resp_cred_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == REFILL_UPDATE) begin
        valid_q[req_idx] <= 1'b1;
        dirty_q[req_idx] <= 1'b0;
      end
      if (data_wen && !write_data_sel) dirty_q[req_idx] <= 1'b1;   // Store word
      mem_cred_q  <= (mem_cred_q & ~memreq_valid) | mem_credit;
      resp_cred_q <= (resp_cred_q & ~cacheresp_valid) | resp_credit;
    end
  end

  cache_bank_dpath u_dpath (
    .clk             (clk),
    .rst_n           (rst_n),
    .bank_req_valid  (bank_req_valid),
    .bank_req        (bank_req),
    .memresp_valid   (memresp_valid),
    .memresp         (memresp),
    .write_data_sel  (write_data_sel),
    .tag_wen         (tag_wen),
    .data_wen        (data_wen),
    .word_en         (word_en),
    .evict_en        (evict_en),
    .memreq_addr_sel (memreq_addr_sel),
    .resp_op         (req_op),
    .mem_op          (mem_op),
    .tag_match       (tag_match),
    .memreq          (memreq),
    .cacheresp       (cacheresp)
  );

endmodule

`default_nettype wire

// ==== src/bank_arbiter.sv ====
// Bank arbiter
// Round-robin memory port sharing and response merge across the banks

`timescale 1ns/1ps
`default_nettype none

module bank_arbiter import cache_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_BANKS-1:0] memreq_valid,
  input  mem_req_t             memreq [NUM_BANKS],
  input  logic [NUM_BANKS-1:0] cacheresp_valid,
  input  cache_resp_t          cacheresp [NUM_BANKS],
  input  logic                 mem_resp_valid,
  input  mem_resp_t            mem_resp,
  output logic [NUM_BANKS-1:0] mem_credit,
  output logic [NUM_BANKS-1:0] resp_credit,
  output logic [NUM_BANKS-1:0] memresp_valid,
  output mem_resp_t            memresp,
  output logic                 mem_req_valid,
  output mem_req_t             mem_req,
  output logic                 resp_valid,
  output cache_resp_t          resp
);

  mem_req_t             mslot_q [NUM_BANKS];
  cache_resp_t          rslot_q [NUM_BANKS];
  logic [NUM_BANKS-1:0] mpend_q, rpend_q;
  logic [BANK_W-1:0]    mem_rr_q, resp_rr_q, owner_q;
  logic [BANK_W-1:0]    mem_gnt, resp_gnt;
  logic [NUM_BANKS-1:0] mem_issue_mask, resp_gnt_mask;
  logic                 busy_q, resp_grant;

  // Next pending slot after the last grant
  function automatic logic [BANK_W-1:0] rr_pick(input logic [NUM_BANKS-1:0] pend,
                                                input logic [BANK_W-1:0]    last);
    logic [BANK_W-1:0] cand;
    rr_pick = last;
    for (int i = NUM_BANKS; i >= 1; i--) begin
      cand = last + BANK_W'(i);
      if (pend[cand]) rr_pick = cand;
    end
  endfunction

  assign mem_gnt       = rr_pick(mpend_q, mem_rr_q);
  assign resp_gnt      = rr_pick(rpend_q, resp_rr_q);
  assign mem_req_valid = !busy_q && (mpend_q != '0);   // One transaction at a time
  assign mem_req       = mslot_q[mem_gnt];
  assign resp_grant    = (rpend_q != '0);

  always_comb begin
    mem_issue_mask           = '0;
    mem_issue_mask[mem_gnt]  = mem_req_valid;
    resp_gnt_mask            = '0;
    resp_gnt_mask[resp_gnt]  = resp_grant;
    memresp_valid            = '0;
    memresp_valid[owner_q]   = mem_resp_valid;
  end

  assign mem_credit = memresp_valid;   // Slot frees when memory answers
  assign memresp    = mem_resp;

  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (memreq_valid[b]) mslot_q[b] <= memreq[b];
      if (cacheresp_valid[b]) rslot_q[b] <= cacheresp[b];
    end
    if (resp_grant) resp <= rslot_q[resp_gnt];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mpend_q     <= '0;
      rpend_q     <= '0;
      mem_rr_q    <= '0;
      resp_rr_q   <= '0;
      owner_q     <= '0;
      busy_q      <= 1'b0;
      resp_valid  <= 1'b0;
      resp_credit <= '0;
    end else begin
      mpend_q <= (mpend_q & ~mem_issue_mask) | memreq_valid;
      rpend_q <= (rpend_q & ~resp_gnt_mask) | cacheresp_valid;
      if (mem_req_valid) begin
        busy_q   <= 1'b1;
        owner_q  <= mem_gnt;
        mem_rr_q <= mem_gnt;
      end else if (mem_resp_valid) begin
        busy_q <= 1'b0;
      end
      if (resp_grant) resp_rr_q <= resp_gnt;
      resp_valid  <= resp_grant;
      resp_credit <= resp_gnt_mask;   // Same cycle as resp_valid
    end
  end

endmodule

`default_nettype wire

// ==== src/banked_cache.sv ====
// Four-bank blocking data cache
// Router, generated banks and the memory and response arbiter

`timescale 1ns/1ps
`default_nettype none

module banked_cache import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid,
  input  cache_req_t  req,
  output logic        req_credit,
  output logic        resp_valid,
  output cache_resp_t resp,
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  input  logic        mem_resp_valid,
  input  mem_resp_t   mem_resp
);

  logic [NUM_BANKS-1:0] bank_req_valid, bank_req_credit;
  cache_req_t           bank_req;
  logic [NUM_BANKS-1:0] memreq_valid, mem_credit, memresp_valid;
  mem_req_t             memreq [NUM_BANKS];
  mem_resp_t            memresp;
  logic [NUM_BANKS-1:0] cacheresp_valid, resp_credit;
  cache_resp_t          cacheresp [NUM_BANKS];

  bank_router u_router (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid       (req_valid),
    .req             (req),
    .bank_req_credit (bank_req_credit),
    .req_credit      (req_credit),
    .bank_req_valid  (bank_req_valid),
    .bank_req        (bank_req)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    cache_bank u_bank (
      .clk             (clk),
      .rst_n           (rst_n),
      .bank_req_valid  (bank_req_valid[b]),
      .bank_req        (bank_req),
      .mem_credit      (mem_credit[b]),
      .memresp_valid   (memresp_valid[b]),
      .memresp         (memresp),
      .resp_credit     (resp_credit[b]),
      .bank_req_credit (bank_req_credit[b]),
      .memreq_valid    (memreq_valid[b]),
      .memreq          (memreq[b]),
      .cacheresp_valid (cacheresp_valid[b]),
      .cacheresp       (cacheresp[b])
    );
  end

  bank_arbiter u_arbiter (
    .clk             (clk),
    .rst_n           (rst_n),
    .memreq_valid    (memreq_valid),
    .memreq          (memreq),
    .cacheresp_valid (cacheresp_valid),
    .cacheresp       (cacheresp),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp        (mem_resp),
    .mem_credit      (mem_credit),
    .resp_credit     (resp_credit),
    .memresp_valid   (memresp_valid),
    .memresp         (memresp),
    .mem_req_valid   (mem_req_valid),
    .mem_req         (mem_req),
    .resp_valid      (resp_valid),
    .resp            (resp)
  );

endmodule

`default_nettype wire

// ==== tests/tb_mem_model.sv ====
// Behavioral line memory
// Word A holds A ^ 5a5a_0000 until written, answers after 1 to 4 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      mem_req_valid,
  input  mem_req_t  mem_req,
  output logic      mem_resp_valid,
  output mem_resp_t mem_resp
);

  logic [DATA_W-1:0] words [logic [29:0]];   // Only written words live here
  mem_req_t          pend_q;
  int                delay_q;
  logic              busy_q;

  function automatic logic [DATA_W-1:0] read_word(input logic [29:0] a);
    if (words.exists(a)) return words[a];
    return {2'b00, a} ^ 32'h5a5a_0000;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    logic [29:0]       base;
    logic [LINE_W-1:0] line;
    if (!rst_n) begin
      busy_q         <= 1'b0;
      delay_q        <= 0;
      mem_resp_valid <= 1'b0;
      mem_resp       <= '0;
    end else begin
      mem_resp_valid <= 1'b0;
      if (mem_req_valid) begin
        pend_q  <= mem_req;
        delay_q <= 1 + int'($urandom % 4);
        busy_q  <= 1'b1;
      end else if (busy_q) begin
        if (delay_q == 1) begin
          base = {pend_q.addr[31:4], 2'b00};
          line = '0;
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (pend_q.op == MEM_WRITE) words[base + 30'(w)] = pend_q.data[w*DATA_W +: DATA_W];
            else line[w*DATA_W +: DATA_W] = read_word(base + 30'(w));
          end
          mem_resp.op    <= pend_q.op;
          mem_resp.data  <= line;
          mem_resp_valid <= 1'b1;
          busy_q         <= 1'b0;
        end else begin
          delay_q <= delay_q - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/banked_cache_sva.sv ====
// Banked cache assertions
// Reset quiet outputs and per-bank credit bounds

`timescale 1ns/1ps
`default_nettype none

module banked_cache_sva import cache_pkg::*; (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 resp_valid,
  input logic                 mem_req_valid,
  input logic                 req_credit,
  input logic [NUM_BANKS-1:0] bank_req_valid,
  input logic [NUM_BANKS-1:0] bank_req_credit,
  input logic [NUM_BANKS-1:0] memreq_valid,
  input logic [NUM_BANKS-1:0] mem_credit,
  input logic [NUM_BANKS-1:0] cacheresp_valid,
  input logic [NUM_BANKS-1:0] resp_credit
);

  logic [NUM_BANKS-1:0] bank_cred_q;   // Shadow of the router credits
  logic [NUM_BANKS-1:0] mem_cred_q;    // Shadow of the bank memory credits
  logic [NUM_BANKS-1:0] resp_cred_q;   // Shadow of the bank response credits

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_cred_q <= '1;
      mem_cred_q  <= '1;
      resp_cred_q <= '1;
    end else begin
      bank_cred_q <= (bank_cred_q & ~bank_req_valid) | bank_req_credit;
      mem_cred_q  <= (mem_cred_q & ~memreq_valid) | mem_credit;
      resp_cred_q <= (resp_cred_q & ~cacheresp_valid) | resp_credit;
    end
  end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !resp_valid && !mem_req_valid && !req_credit)
    else $error("Outputs active during reset");

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_cred
    cred_max_one: assert property (@(posedge clk) disable iff (!rst_n)
      bank_req_credit[b] |-> !bank_cred_q[b])
      else $error("Bank credit above one");
    mem_cred_max_one: assert property (@(posedge clk) disable iff (!rst_n)
      mem_credit[b] |-> !mem_cred_q[b])
      else $error("Memory credit above one");
    resp_cred_max_one: assert property (@(posedge clk) disable iff (!rst_n)
      resp_credit[b] |-> !resp_cred_q[b])
      else $error("Response credit above one");
  end

endmodule

bind banked_cache banked_cache_sva u_sva (
  .clk             (clk),
  .rst_n           (rst_n),
  .resp_valid      (resp_valid),
  .mem_req_valid   (mem_req_valid),
  .req_credit      (req_credit),
  .bank_req_valid  (bank_req_valid),
  .bank_req_credit (bank_req_credit),
  .memreq_valid    (memreq_valid),
  .mem_credit      (mem_credit),
  .cacheresp_valid (cacheresp_valid),
  .resp_credit     (resp_credit)
);

`default_nettype wire

// ==== tests/tb_banked_cache.sv ====
// Banked cache testbench
// Directed table, random phase against a shadow memory, credit tracking

`timescale 1ns/1ps
`default_nettype none

module tb_banked_cache import cache_pkg::*; ();

  localparam int TABLE_LEN  = 20;
  localparam int NUM_RANDOM = 200;
  localparam int MAX_CYCLES = 40 * (TABLE_LEN + NUM_RANDOM);

  logic        clk, rst_n;
  logic        req_valid, req_credit, resp_valid;
  cache_req_t  req;
  cache_resp_t resp;
  logic        mem_req_valid, mem_resp_valid;
  mem_req_t    mem_req;
  mem_resp_t   mem_resp;

  // Stimulus table
  cache_op_e   t_op   [TABLE_LEN];
  logic [31:0] t_addr [TABLE_LEN];
  logic [31:0] t_data [TABLE_LEN];
  logic [31:0] t_exp  [TABLE_LEN];
  int          rows;

  // Scoreboard by opaque
  logic        pending  [256];
  logic [31:0] exp_data [256];
  cache_op_e   exp_op   [256];
  logic [31:0] shadow [logic [29:0]];
  logic [7:0]  next_opq;
  int          issued, returned, resp_count, cycles;
  int          mismatches, other_errors;

  banked_cache DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req            (req),
    .req_credit     (req_credit),
    .resp_valid     (resp_valid),
    .resp           (resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp)
  );

  tb_mem_model u_mem (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] shadow_read(input logic [31:0] addr);
    if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
    return pattern_word(addr);
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      mismatches++;
    end
  endtask

  task automatic add_row(input cache_op_e op, input logic [31:0] addr,
                         input logic [31:0] data, input logic [31:0] exp);
    t_op[rows]   = op;
    t_addr[rows] = addr;
    t_data[rows] = data;
    t_exp[rows]  = exp;
    rows++;
  endtask

  // Waits for a client credit, then drives one request
  task automatic send(input cache_op_e op, input logic [31:0] addr,
                      input logic [31:0] data, input logic [31:0] exp);
    @(posedge clk);
    req_valid <= 1'b0;
    while (issued - returned >= CLIENT_CREDITS) @(posedge clk);
    pending[next_opq]  = 1'b1;
    exp_data[next_opq] = (op == OP_READ) ? exp : 32'h0;
    exp_op[next_opq]   = op;
    if (op == OP_WRITE) shadow[addr[31:2]] = data;
    req_valid   <= 1'b1;
    req.op      <= op;
    req.opaque  <= next_opq;
    req.addr    <= addr;
    req.data    <= data;
    next_opq++;
    issued++;
  endtask

  // ------------------------------
  // Monitors and timeout
  // ------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      cycles++;
      if (req_credit) begin
        if (returned >= issued) begin
          $display("Client credit returned with no request outstanding");
          other_errors++;
        end
        returned++;
      end
      if (resp_valid) begin
        if (!pending[resp.opaque]) begin
          $display("Unexpected response with opaque %h", resp.opaque);
          other_errors++;
        end else begin
          check_equal(32'(resp.op), 32'(exp_op[resp.opaque]), "response op");
          check_equal(resp.data, exp_data[resp.opaque], "response data");
          pending[resp.opaque] = 1'b0;
        end
        resp_count++;
      end
      if (cycles > MAX_CYCLES) begin
        $display("Timeout after %0d cycles with %0d of %0d responses", cycles,
                 resp_count, issued);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    cache_op_e   op;
    void'($urandom(32'hbee6_d45e));
    rst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    next_opq = '0;
    issued = 0;
    returned = 0;
    resp_count = 0;
    cycles = 0;
    mismatches = 0;
    other_errors = 0;
    rows = 0;
    for (int i = 0; i < 256; i++) pending[i] = 1'b0;

    add_row(OP_READ,  32'h0000_1000, 32'h0, pattern_word(32'h0000_1000));  // Untouched lines
    add_row(OP_READ,  32'h0000_1014, 32'h0, pattern_word(32'h0000_1014));
    add_row(OP_WRITE, 32'h0000_1004, 32'haaaa_0001, 32'h0);
    add_row(OP_READ,  32'h0000_1004, 32'h0, 32'haaaa_0001);                // Hit
    add_row(OP_WRITE, 32'h0000_0010, 32'h1111_0000, 32'h0);  // Bank 1 index 0, three tags
    add_row(OP_WRITE, 32'h0000_0210, 32'h2222_0000, 32'h0);
    add_row(OP_WRITE, 32'h0000_0410, 32'h3333_0000, 32'h0);
    add_row(OP_READ,  32'h0000_0010, 32'h0, 32'h1111_0000);
    add_row(OP_READ,  32'h0000_0210, 32'h0, 32'h2222_0000);
    add_row(OP_READ,  32'h0000_0410, 32'h0, 32'h3333_0000);
    add_row(OP_READ,  32'h0000_1204, 32'h0, pattern_word(32'h0000_1204));  // Evicts 0x1000
    add_row(OP_READ,  32'h0000_1004, 32'h0, 32'haaaa_0001);                // Refilled
    add_row(OP_READ,  32'h0000_2000, 32'h0, pattern_word(32'h0000_2000));  // All four banks
    add_row(OP_READ,  32'h0000_2010, 32'h0, pattern_word(32'h0000_2010));
    add_row(OP_READ,  32'h0000_2020, 32'h0, pattern_word(32'h0000_2020));
    add_row(OP_READ,  32'h0000_2030, 32'h0, pattern_word(32'h0000_2030));
    add_row(OP_WRITE, 32'h0000_2024, 32'hcccc_0002, 32'h0);
    add_row(OP_WRITE, 32'h0000_2038, 32'hdddd_0003, 32'h0);
    add_row(OP_READ,  32'h0000_2024, 32'h0, 32'hcccc_0002);
    add_row(OP_READ,  32'h0000_2038, 32'h0, 32'hdddd_0003);

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < TABLE_LEN; i++) begin
      send(t_op[i], t_addr[i], t_data[i], t_exp[i]);
    end

    // Random phase over four tags so conflicts and write-backs happen
    for (int i = 0; i < NUM_RANDOM; i++) begin
      addr = ($urandom % 2048) & 32'hffff_fffc;
      data = $urandom;
      op   = ($urandom % 2 == 0) ? OP_READ : OP_WRITE;
      send(op, addr, data, shadow_read(addr));
    end
    @(posedge clk);
    req_valid <= 1'b0;

    while (resp_count < issued || returned < issued) @(posedge clk);
    repeat (4) @(posedge clk);

    $display("Errors: %0d mismatches, %0d other, %0d responses for %0d requests",
             mismatches, other_errors, resp_count, issued);
    if (mismatches == 0 && other_errors == 0 && resp_count == issued) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/cache_pkg.sv
src/bank_router.sv
src/cache_bank_dpath.sv
src/cache_bank.sv
src/bank_arbiter.sv
src/banked_cache.sv
tests/tb_mem_model.sv
tests/banked_cache_sva.sv
tests/tb_banked_cache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the banked cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_banked_cache -f files.f -o sim_banked_cache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_banked_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1
